// File: clint_slice.sv
`timescale 1ns/1ps
`default_nettype none

`include "uncore_params.svh"

module clint_slice
  import uncore_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  mem_msg_s cmd_i,
  input  logic     cmd_v_i,
  output logic     cmd_ready_o,

  output mem_msg_s resp_o,
  output logic     resp_v_o,
  input  logic     resp_yumi_i,

  output logic     timer_irq_o,
  output logic     software_irq_o
);

  logic [`DATA_WIDTH-1:0]        mtime_q;
  logic [`DATA_WIDTH-1:0]        mtimecmp_q;
  logic                          msip_q;
  logic [`DATA_WIDTH-1:0]        rdata;
  logic [`CLINT_OFFSET_WIDTH-1:0] offset;
  logic                          accept;
  logic                          is_wr;
  mem_msg_s                      resp_q;
  logic                          resp_v_q;

  // One command in flight
  assign cmd_ready_o = !resp_v_q;
  assign accept      = cmd_v_i && cmd_ready_o;
  assign is_wr       = accept && (cmd_i.header.msg_type == e_mem_wr);
  assign offset      = cmd_i.header.addr[`CLINT_OFFSET_WIDTH-1:0];

  always_comb
  begin
    case (offset)
      `MSIP_OFFSET:     rdata = {{(`DATA_WIDTH-1){1'b0}}, msip_q};
      `MTIMECMP_OFFSET: rdata = mtimecmp_q;
      `MTIME_OFFSET:    rdata = mtime_q;
      default:          rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end
    else
    begin
      if (is_wr && offset == `MTIME_OFFSET)
        mtime_q <= cmd_i.data;
      else
        mtime_q <= mtime_q + 1'b1;
      if (is_wr && offset == `MTIMECMP_OFFSET)
        mtimecmp_q <= cmd_i.data;
      if (is_wr && offset == `MSIP_OFFSET)
        msip_q <= cmd_i.data[0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      resp_v_q <= 1'b0;
    else if (accept)
      resp_v_q <= 1'b1;
    else if (resp_yumi_i)
      resp_v_q <= 1'b0;
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_q.header <= cmd_i.header;
      resp_q.data   <= is_wr ? '0 : rdata;
    end
  end

  assign resp_o   = resp_q;
  assign resp_v_o = resp_v_q;

  assign software_irq_o = msip_q;
  assign timer_irq_o    = (mtime_q >= mtimecmp_q);

endmodule

`default_nettype wire

// File: cmd_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "uncore_params.svh"

module cmd_router
  import uncore_pkg::*;
(
  input  mem_msg_s [`NUM_REQ-1:0] req_cmd_i,
  input  logic [`NUM_REQ-1:0]     req_cmd_v_i,
  output logic [`NUM_REQ-1:0]     req_cmd_yumi_o,

  input  logic [`NUM_TGT-1:0]     tgt_ready_i,
  output mem_msg_s                tgt_cmd_o,
  output logic [`NUM_TGT-1:0]     tgt_cmd_v_o
);

  localparam int unsigned MsgWidth = $bits(mem_msg_s);

  logic                          all_ready;
  logic                          any_grant;
  logic [MsgWidth-1:0]           sel_bits;
  mem_msg_s                      sel_cmd;

  logic [`PADDR_WIDTH-1:0]       addr;
  logic [`DEV_WIDTH-1:0]         dev;
  logic                          is_local;
  logic                          is_other_domain;
  logic                          is_io;
  logic                          is_mem;
  logic                          is_clint;
  logic                          is_loopback;

  // A single stalled target holds off every requester
  assign all_ready = &tgt_ready_i;

  fixed_arbiter
  #(
    .inputs_p(`NUM_REQ)
  )
  i_cmd_arb
  (
    .ready_i (all_ready),
    .reqs_i  (req_cmd_v_i),
    .grants_o(req_cmd_yumi_o)
  );

  assign any_grant = |req_cmd_yumi_o;

  // One-hot AND-OR select of the granted command
  always_comb
  begin
    sel_bits = '0;
    for (int i = 0; i < `NUM_REQ; i++)
    begin
      sel_bits = sel_bits | (req_cmd_i[i] & {MsgWidth{req_cmd_yumi_o[i]}});
    end
  end

  assign sel_cmd   = mem_msg_s'(sel_bits);
  assign tgt_cmd_o = sel_cmd;

  // Address decode
  assign addr            = sel_cmd.header.addr;
  assign dev             = addr[`DEV_LSB +: `DEV_WIDTH];
  assign is_local        = (addr < `DRAM_BASE);
  assign is_other_domain = (addr[`PADDR_WIDTH-1 -: `DOMAIN_WIDTH] != '0);

  assign is_io       = (is_local && (dev == `BOOT_DEV || dev == `HOST_DEV)) || is_other_domain;
  assign is_mem      = (!is_local && !is_other_domain) || (is_local && dev == `CACHE_DEV);
  assign is_clint    = is_local && (dev == `CLINT_DEV);
  // CFG and every unknown device end up here
  assign is_loopback = is_local && !is_io && !is_mem && !is_clint;

  always_comb
  begin
    tgt_cmd_v_o                = '0;
    tgt_cmd_v_o[`TGT_LOOPBACK] = any_grant && is_loopback;
    tgt_cmd_v_o[`TGT_MEM]      = any_grant && is_mem;
    tgt_cmd_v_o[`TGT_IO]       = any_grant && is_io;
    tgt_cmd_v_o[`TGT_CLINT]    = any_grant && is_clint;
  end

endmodule

`default_nettype wire

// File: fixed_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module fixed_arbiter
#(
  parameter int unsigned inputs_p = 2
)
(
  input  logic                ready_i,
  input  logic [inputs_p-1:0] reqs_i,
  output logic [inputs_p-1:0] grants_o
);

  logic found;

  // Highest index has priority
  always_comb
  begin
    grants_o = '0;
    found = 1'b0;
    for (int i = inputs_p - 1; i >= 0; i--)
    begin
      if (ready_i && reqs_i[i] && !found)
      begin
        grants_o[i] = 1'b1;
        found = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: loopback_target.sv
`timescale 1ns/1ps
`default_nettype none

`include "uncore_params.svh"

module loopback_target
  import uncore_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  mem_msg_s cmd_i,
  input  logic     cmd_v_i,
  output logic     cmd_ready_o,

  output mem_msg_s resp_o,
  output logic     resp_v_o,
  input  logic     resp_yumi_i
);

  logic                     accept;
  logic                     resp_v_q;
  mem_header_s              resp_header_q;

  assign cmd_ready_o = !resp_v_q;
  assign accept      = cmd_v_i && cmd_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      resp_v_q <= 1'b0;
    else if (accept)
      resp_v_q <= 1'b1;
    else if (resp_yumi_i)
      resp_v_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      resp_header_q <= cmd_i.header;
  end

  // Echo the header, data is always zero
  assign resp_o.header = resp_header_q;
  assign resp_o.data   = `DATA_WIDTH'(0);
  assign resp_v_o      = resp_v_q;

endmodule

`default_nettype wire

// File: resp_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "uncore_params.svh"

module resp_router
  import uncore_pkg::*;
(
  input  mem_msg_s [`NUM_TGT-1:0] tgt_resp_i,
  input  logic [`NUM_TGT-1:0]     tgt_resp_v_i,
  output logic [`NUM_TGT-1:0]     tgt_resp_yumi_o,

  output mem_msg_s [`NUM_REQ-1:0] req_resp_o,
  output logic [`NUM_REQ-1:0]     req_resp_v_o,
  input  logic [`NUM_REQ-1:0]     req_resp_ready_i
);

  localparam int unsigned MsgWidth = $bits(mem_msg_s);

  logic [`NUM_TGT-1:0]  grants;
  logic                 any_resp_v;
  logic                 accepted;
  logic [MsgWidth-1:0]  sel_bits;
  mem_msg_s             sel_resp;

  // Responses never wait on a ready, only on the requester
  fixed_arbiter
  #(
    .inputs_p(`NUM_TGT)
  )
  i_resp_arb
  (
    .ready_i (1'b1),
    .reqs_i  (tgt_resp_v_i),
    .grants_o(grants)
  );

  always_comb
  begin
    sel_bits = '0;
    for (int i = 0; i < `NUM_TGT; i++)
    begin
      sel_bits = sel_bits | (tgt_resp_i[i] & {MsgWidth{grants[i]}});
    end
  end

  assign sel_resp   = mem_msg_s'(sel_bits);
  assign any_resp_v = |tgt_resp_v_i;

  // Steer by lce_id in the header
  for (genvar i = 0; i < `NUM_REQ; i++)
  begin : g_steer
    assign req_resp_o[i]   = sel_resp;
    assign req_resp_v_o[i] = any_resp_v && (sel_resp.header.lce_id == `LCE_ID_WIDTH'(i));
  end

  assign accepted        = |(req_resp_v_o & req_resp_ready_i);
  assign tgt_resp_yumi_o = grants & {`NUM_TGT{accepted}};

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the uncore testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_uncore -f sim.f -o tb_uncore
./obj_dir/tb_uncore

// File: sim.f
+incdir+.
uncore_pkg.sv
fixed_arbiter.sv
cmd_router.sv
resp_router.sv
clint_slice.sv
loopback_target.sv
uncore_top.sv
tb_uncore.sv

// File: tb_uncore.sv
`timescale 1ns/1ps
`default_nettype none

`include "uncore_params.svh"

module tb_uncore
  import uncore_pkg::*;
();

  localparam int NUM_RAND        = 40;
  // Per command budget covers arbitration among three requesters and random ready
  localparam int EXPECTED_CYCLES = NUM_RAND * 20 + 400;
  localparam int TIMEOUT_CYCLES  = 2 * EXPECTED_CYCLES;

  localparam int T_LOOP  = 0;
  localparam int T_MEM   = 1;
  localparam int T_IO    = 2;
  localparam int T_CLINT = 3;

  localparam logic [63:0] MEM_KEY = 64'h5a5a_0f0f_a5a5_f0f0;
  localparam logic [63:0] IO_KEY  = 64'h1234_5678_9abc_def0;

  logic                    clk_i;
  logic                    rst_n_i;
  mem_msg_s [2:0]          req_cmd_i;
  logic [2:0]              req_cmd_v_i;
  logic [2:0]              req_cmd_yumi_o;
  mem_msg_s [2:0]          req_resp_o;
  logic [2:0]              req_resp_v_o;
  logic [2:0]              req_resp_ready_i;
  mem_msg_s                mem_cmd_o;
  logic                    mem_cmd_v_o;
  logic                    mem_cmd_ready_i;
  mem_msg_s                mem_resp_i;
  logic                    mem_resp_v_i;
  logic                    mem_resp_yumi_o;
  mem_msg_s                io_cmd_o;
  logic                    io_cmd_v_o;
  logic                    io_cmd_ready_i;
  mem_msg_s                io_resp_i;
  logic                    io_resp_v_i;
  logic                    io_resp_yumi_o;
  logic                    timer_irq_o;
  logic                    software_irq_o;

  // Scoreboard state, one outstanding command per requester
  mem_msg_s                exp_resp [3];
  logic                    exp_known [3];
  logic                    pending [3];
  int                      pend_tgt [3];
  mem_msg_s                last_resp [3];
  mem_msg_s                mem_q [$];
  mem_msg_s                io_q [$];
  int                      grant_log [$];
  logic                    hold_mem;
  int                      cycles;

  mem_msg_s                mon_cmd;
  int                      mon_tgt;
  logic [2:0]              mon_yumi;
  logic                    loop_busy;
  logic                    clint_busy;
  int                      yumi_tgt;
  logic [63:0]             t0;
  logic [63:0]             t1;
  int                      wait_cycles;
  mem_msg_s                cfg_cmd;

  uncore_top i_dut
  (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_cmd_i       (req_cmd_i),
    .req_cmd_v_i     (req_cmd_v_i),
    .req_cmd_yumi_o  (req_cmd_yumi_o),
    .req_resp_o      (req_resp_o),
    .req_resp_v_o    (req_resp_v_o),
    .req_resp_ready_i(req_resp_ready_i),
    .mem_cmd_o       (mem_cmd_o),
    .mem_cmd_v_o     (mem_cmd_v_o),
    .mem_cmd_ready_i (mem_cmd_ready_i),
    .mem_resp_i      (mem_resp_i),
    .mem_resp_v_i    (mem_resp_v_i),
    .mem_resp_yumi_o (mem_resp_yumi_o),
    .io_cmd_o        (io_cmd_o),
    .io_cmd_v_o      (io_cmd_v_o),
    .io_cmd_ready_i  (io_cmd_ready_i),
    .io_resp_i       (io_resp_i),
    .io_resp_v_i     (io_resp_v_i),
    .io_resp_yumi_o  (io_resp_yumi_o),
    .timer_irq_o     (timer_irq_o),
    .software_irq_o  (software_irq_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "check failed");
    end
  endtask

  function automatic int expected_target(input logic [39:0] addr);
    logic       is_local;
    logic       other;
    logic [3:0] dev;
    is_local = addr < `DRAM_BASE;
    other    = addr[39:37] != 3'b000;
    dev      = addr[23:20];
    if (other || (is_local && (dev == `BOOT_DEV || dev == `HOST_DEV)))
      return T_IO;
    if (!is_local || dev == `CACHE_DEV)
      return T_MEM;
    if (dev == `CLINT_DEV)
      return T_CLINT;
    return T_LOOP;
  endfunction

  function automatic mem_msg_s expected_resp(input mem_msg_s cmd);
    mem_msg_s resp;
    resp.header = cmd.header;
    case (expected_target(cmd.header.addr))
      T_MEM:   resp.data = {24'h0, cmd.header.addr} ^ MEM_KEY;
      T_IO:    resp.data = {24'h0, cmd.header.addr} ^ IO_KEY;
      default: resp.data = '0;
    endcase
    return resp;
  endfunction

  function automatic logic [2:0] highest_valid(input logic [2:0] v);
    if (v[2])
      return 3'b100;
    if (v[1])
      return 3'b010;
    if (v[0])
      return 3'b001;
    return 3'b000;
  endfunction

  // External target answer: header echoed, data from the address
  function automatic mem_msg_s target_resp(input mem_msg_s cmd, input logic [63:0] key);
    mem_msg_s resp;
    resp.header = cmd.header;
    resp.data   = {24'h0, cmd.header.addr} ^ key;
    return resp;
  endfunction

  function automatic mem_msg_s random_cmd(input int i);
    mem_msg_s    cmd;
    logic [63:0] r;
    logic [3:0]  dev;
    r   = {$urandom, $urandom};
    dev = 4'($urandom);
    if (dev == `CLINT_DEV)
      dev = `CFG_DEV;
    cmd.header.msg_type = ($urandom % 2 != 0) ? e_mem_wr : e_mem_rd;
    cmd.header.lce_id   = 2'(i);
    case ($urandom % 4)
      0:       cmd.header.addr = {3'b000, r[36:0]} | `DRAM_BASE;
      1:       cmd.header.addr = {3'(1 + $urandom % 7), r[36:0]};
      default: cmd.header.addr = {9'h0, r[30:24], dev, r[19:0]};
    endcase
    cmd.data = {$urandom, $urandom};
    return cmd;
  endfunction

  task automatic send(input int i, input mem_msg_s cmd, input mem_msg_s exp, input logic known);
    @(negedge clk_i);
    exp_resp[i]    = exp;
    exp_known[i]   = known;
    req_cmd_i[i]   = cmd;
    req_cmd_v_i[i] = 1'b1;
    @(posedge clk_i);
    while (!req_cmd_yumi_o[i])
      @(posedge clk_i);
    @(negedge clk_i);
    req_cmd_v_i[i] = 1'b0;
    wait (!pending[i]);
  endtask

  task automatic run_random(input int i);
    mem_msg_s cmd;
    repeat (NUM_RAND)
    begin
      cmd = random_cmd(i);
      send(i, cmd, expected_resp(cmd), 1'b1);
    end
  endtask

  task automatic send_mem(input int i);
    mem_msg_s cmd;
    cmd = random_cmd(i);
    cmd.header.addr = `DRAM_BASE | 40'(i << 6);
    send(i, cmd, expected_resp(cmd), 1'b1);
  endtask

  task automatic clint_access(input mem_msg_type_e op, input logic [15:0] offset,
                              input logic [63:0] wdata, input logic [63:0] rdata,
                              input logic known);
    mem_msg_s cmd;
    mem_msg_s exp;
    cmd.header.msg_type = op;
    cmd.header.lce_id   = 2'd1;
    cmd.header.addr     = {16'h0, `CLINT_DEV, 4'h0, offset};
    cmd.data            = wdata;
    exp.header          = cmd.header;
    exp.data            = (op == e_mem_wr) ? 64'h0 : rdata;
    send(1, cmd, exp, known);
  endtask

  // Memory and I/O models with random ready
  task automatic drive_targets();
    forever
    begin
      @(negedge clk_i);
      mem_cmd_ready_i  = !hold_mem && ($urandom % 4 != 0);
      io_cmd_ready_i   = $urandom % 4 != 0;
      req_resp_ready_i = 3'($urandom);
      mem_resp_v_i     = mem_q.size() != 0;
      io_resp_v_i      = io_q.size() != 0;
      if (mem_q.size() != 0)
        mem_resp_i = target_resp(mem_q[0], MEM_KEY);
      if (io_q.size() != 0)
        io_resp_i = target_resp(io_q[0], IO_KEY);
    end
  endtask

  always @(posedge clk_i)
  begin
    if (rst_n_i)
      cycles++;
    if (cycles > TIMEOUT_CYCLES)
    begin
      $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  always @(posedge clk_i)
  begin
    if (rst_n_i)
    begin
      // Internal targets refuse commands while their response is held
      loop_busy  = 1'b0;
      clint_busy = 1'b0;
      for (int i = 0; i < 3; i++)
      begin
        if (pending[i] && pend_tgt[i] == T_LOOP)
          loop_busy = 1'b1;
        if (pending[i] && pend_tgt[i] == T_CLINT)
          clint_busy = 1'b1;
      end
      mon_yumi = 3'b000;
      if (mem_cmd_ready_i && io_cmd_ready_i && !loop_busy && !clint_busy)
        mon_yumi = highest_valid(req_cmd_v_i);
      check("command grant", 128'(req_cmd_yumi_o), 128'(mon_yumi));
      mon_cmd = '0;
      mon_tgt = -1;
      for (int i = 0; i < 3; i++)
      begin
        if (req_cmd_yumi_o[i])
        begin
          check("command while pending", 128'(pending[i]), 128'(0));
          mon_cmd     = req_cmd_i[i];
          mon_tgt     = expected_target(mon_cmd.header.addr);
          pending[i]  = 1'b1;
          pend_tgt[i] = mon_tgt;
          grant_log.push_back(i);
        end
      end
      check("mem_cmd_v_o", 128'(mem_cmd_v_o), 128'(mon_tgt == T_MEM));
      check("io_cmd_v_o", 128'(io_cmd_v_o), 128'(mon_tgt == T_IO));
      if (mon_tgt == T_MEM)
      begin
        check("mem_cmd_o", 128'(mem_cmd_o), 128'(mon_cmd));
        mem_q.push_back(mon_cmd);
      end
      if (mon_tgt == T_IO)
      begin
        check("io_cmd_o", 128'(io_cmd_o), 128'(mon_cmd));
        io_q.push_back(mon_cmd);
      end
      check("single response valid", 128'($countones(req_resp_v_o) <= 1), 128'(1));
      yumi_tgt = -1;
      for (int i = 0; i < 3; i++)
      begin
        if (req_resp_v_o[i] && req_resp_ready_i[i])
        begin
          check("response without command", 128'(pending[i]), 128'(1));
          check("response lce_id", 128'(req_resp_o[i].header.lce_id), 128'(i));
          if (exp_known[i])
            check("response message", 128'(req_resp_o[i]), 128'(exp_resp[i]));
          last_resp[i] = req_resp_o[i];
          pending[i]   = 1'b0;
          yumi_tgt     = pend_tgt[i];
        end
      end
      check("mem_resp_yumi_o", 128'(mem_resp_yumi_o), 128'(yumi_tgt == T_MEM));
      check("io_resp_yumi_o", 128'(io_resp_yumi_o), 128'(yumi_tgt == T_IO));
      if (mem_resp_yumi_o)
        void'(mem_q.pop_front());
      if (io_resp_yumi_o)
        void'(io_q.pop_front());
    end
  end

  initial
  begin
    void'($urandom(56));
    rst_n_i          = 1'b0;
    req_cmd_i        = '0;
    req_cmd_v_i      = '0;
    req_resp_ready_i = '0;
    mem_cmd_ready_i  = 1'b0;
    mem_resp_i       = '0;
    mem_resp_v_i     = 1'b0;
    io_cmd_ready_i   = 1'b0;
    io_resp_i        = '0;
    io_resp_v_i      = 1'b0;
    hold_mem         = 1'b0;
    cycles           = 0;
    for (int i = 0; i < 3; i++)
    begin
      pending[i]   = 1'b0;
      pend_tgt[i]  = -1;
      exp_known[i] = 1'b0;
    end
    fork
      drive_targets();
    join_none
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    check("outputs idle after reset",
          128'({req_cmd_yumi_o, req_resp_v_o, mem_cmd_v_o, io_cmd_v_o,
                mem_resp_yumi_o, io_resp_yumi_o, timer_irq_o, software_irq_o}), 128'(0));
    rst_n_i = 1'b1;

    // Routing, steering and loopback from all requesters at once
    fork
      run_random(0);
      run_random(1);
      run_random(2);
    join

    cfg_cmd = random_cmd(0);
    cfg_cmd.header.addr = {16'h0, `CFG_DEV, 20'h00100};
    cfg_cmd.header.msg_type = e_mem_rd;
    send(0, cfg_cmd, expected_resp(cfg_cmd), 1'b1);
    cfg_cmd.header.msg_type = e_mem_wr;
    send(0, cfg_cmd, expected_resp(cfg_cmd), 1'b1);

    // Memory stall with all three requesters waiting
    grant_log.delete();
    @(posedge clk_i);
    hold_mem = 1'b1;
    fork
      begin
        repeat (20) @(posedge clk_i);
        hold_mem = 1'b0;
      end
      send_mem(0);
      send_mem(1);
      send_mem(2);
    join
    check("grant order", 128'(grant_log[0] * 100 + grant_log[1] * 10 + grant_log[2]), 128'(210));

    clint_access(e_mem_wr, `MSIP_OFFSET, 64'h1, 64'h0, 1'b1);
    check("software_irq_o set", 128'(software_irq_o), 128'(1));
    clint_access(e_mem_rd, `MSIP_OFFSET, 64'h0, 64'h1, 1'b1);
    clint_access(e_mem_wr, `MSIP_OFFSET, 64'h0, 64'h0, 1'b1);
    check("software_irq_o clear", 128'(software_irq_o), 128'(0));
    clint_access(e_mem_wr, `MTIMECMP_OFFSET, 64'hdead_beef_0000_1234, 64'h0, 1'b1);
    clint_access(e_mem_rd, `MTIMECMP_OFFSET, 64'h0, 64'hdead_beef_0000_1234, 1'b1);
    clint_access(e_mem_rd, `MTIME_OFFSET, 64'h0, 64'h0, 1'b0);
    t0 = last_resp[1].data;
    clint_access(e_mem_rd, `MTIME_OFFSET, 64'h0, 64'h0, 1'b0);
    t1 = last_resp[1].data;
    check("mtime increases", 128'(t1 > t0), 128'(1));
    clint_access(e_mem_wr, `MTIMECMP_OFFSET, t1 + 64'd40, 64'h0, 1'b1);
    check("timer_irq_o before compare", 128'(timer_irq_o), 128'(0));
    wait_cycles = 0;
    while (!timer_irq_o)
    begin
      @(posedge clk_i);
      wait_cycles++;
      if (wait_cycles > 100)
      begin
        $display("timer_irq_o did not rise within 100 cycles of the mtimecmp write");
        $display("SOME TESTS FAILED");
        $fatal(1, "timer interrupt missing");
      end
    end

    repeat (4) @(posedge clk_i);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: uncore_params.svh
`ifndef UNCORE_PARAMS_SVH
`define UNCORE_PARAMS_SVH

`define PADDR_WIDTH 40
`define DATA_WIDTH 64
`define LCE_ID_WIDTH 2
`define DOMAIN_WIDTH 3

// Local address map
`define DEV_LSB 20
`define DEV_WIDTH 4
`define DRAM_BASE 40'h00_8000_0000

`define BOOT_DEV 4'd0
`define HOST_DEV 4'd1
`define CFG_DEV 4'd2
`define CLINT_DEV 4'd3
`define CACHE_DEV 4'd4

// CLINT register offsets, low 16 address bits
`define CLINT_OFFSET_WIDTH 16
`define MSIP_OFFSET 16'h0000
`define MTIMECMP_OFFSET 16'h4000
`define MTIME_OFFSET 16'hBFF8

`define NUM_REQ 3
`define NUM_TGT 4

// Target slots, also the response priority (highest index wins)
`define TGT_CLINT 0
`define TGT_IO 1
`define TGT_MEM 2
`define TGT_LOOPBACK 3

`endif

// File: uncore_pkg.sv
`default_nettype none

`include "uncore_params.svh"

package uncore_pkg;

  typedef enum logic [1:0]
  {
    e_mem_rd = 2'b00,
    e_mem_wr = 2'b01
  } mem_msg_type_e;

  // 44-bit message header
  typedef struct packed
  {
    mem_msg_type_e                msg_type;
    logic [`LCE_ID_WIDTH-1:0]     lce_id;
    logic [`PADDR_WIDTH-1:0]      addr;
  } mem_header_s;

  // Header plus one data word, 108 bits
  typedef struct packed
  {
    mem_header_s                  header;
    logic [`DATA_WIDTH-1:0]       data;
  } mem_msg_s;

endpackage

`default_nettype wire

// File: uncore_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "uncore_params.svh"

module uncore_top
  import uncore_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  // Requesters: icache engine, dcache engine, incoming I/O
  input  mem_msg_s [`NUM_REQ-1:0] req_cmd_i,
  input  logic [`NUM_REQ-1:0]     req_cmd_v_i,
  output logic [`NUM_REQ-1:0]     req_cmd_yumi_o,
  output mem_msg_s [`NUM_REQ-1:0] req_resp_o,
  output logic [`NUM_REQ-1:0]     req_resp_v_o,
  input  logic [`NUM_REQ-1:0]     req_resp_ready_i,

  // Memory port
  output mem_msg_s                mem_cmd_o,
  output logic                    mem_cmd_v_o,
  input  logic                    mem_cmd_ready_i,
  input  mem_msg_s                mem_resp_i,
  input  logic                    mem_resp_v_i,
  output logic                    mem_resp_yumi_o,

  // Outgoing I/O
  output mem_msg_s                io_cmd_o,
  output logic                    io_cmd_v_o,
  input  logic                    io_cmd_ready_i,
  input  mem_msg_s                io_resp_i,
  input  logic                    io_resp_v_i,
  output logic                    io_resp_yumi_o,

  output logic                    timer_irq_o,
  output logic                    software_irq_o
);

  mem_msg_s                  tgt_cmd;
  logic [`NUM_TGT-1:0]       tgt_ready;
  logic [`NUM_TGT-1:0]       tgt_cmd_v;
  mem_msg_s [`NUM_TGT-1:0]   tgt_resp;
  logic [`NUM_TGT-1:0]       tgt_resp_v;
  logic [`NUM_TGT-1:0]       tgt_resp_yumi;

  logic                      clint_cmd_ready;
  mem_msg_s                  clint_resp;
  logic                      clint_resp_v;
  logic                      loop_cmd_ready;
  mem_msg_s                  loop_resp;
  logic                      loop_resp_v;

  assign tgt_ready[`TGT_LOOPBACK] = loop_cmd_ready;
  assign tgt_ready[`TGT_MEM]      = mem_cmd_ready_i;
  assign tgt_ready[`TGT_IO]       = io_cmd_ready_i;
  assign tgt_ready[`TGT_CLINT]    = clint_cmd_ready;

  cmd_router i_cmd_router
  (
    .req_cmd_i     (req_cmd_i),
    .req_cmd_v_i   (req_cmd_v_i),
    .req_cmd_yumi_o(req_cmd_yumi_o),
    .tgt_ready_i   (tgt_ready),
    .tgt_cmd_o     (tgt_cmd),
    .tgt_cmd_v_o   (tgt_cmd_v)
  );

  assign mem_cmd_o   = tgt_cmd;
  assign mem_cmd_v_o = tgt_cmd_v[`TGT_MEM];
  assign io_cmd_o    = tgt_cmd;
  assign io_cmd_v_o  = tgt_cmd_v[`TGT_IO];

  clint_slice i_clint
  (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cmd_i         (tgt_cmd),
    .cmd_v_i       (tgt_cmd_v[`TGT_CLINT]),
    .cmd_ready_o   (clint_cmd_ready),
    .resp_o        (clint_resp),
    .resp_v_o      (clint_resp_v),
    .resp_yumi_i   (tgt_resp_yumi[`TGT_CLINT]),
    .timer_irq_o   (timer_irq_o),
    .software_irq_o(software_irq_o)
  );

  loopback_target i_loopback
  (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cmd_i      (tgt_cmd),
    .cmd_v_i    (tgt_cmd_v[`TGT_LOOPBACK]),
    .cmd_ready_o(loop_cmd_ready),
    .resp_o     (loop_resp),
    .resp_v_o   (loop_resp_v),
    .resp_yumi_i(tgt_resp_yumi[`TGT_LOOPBACK])
  );

  assign tgt_resp[`TGT_LOOPBACK]   = loop_resp;
  assign tgt_resp[`TGT_MEM]        = mem_resp_i;
  assign tgt_resp[`TGT_IO]         = io_resp_i;
  assign tgt_resp[`TGT_CLINT]      = clint_resp;
  assign tgt_resp_v[`TGT_LOOPBACK] = loop_resp_v;
  assign tgt_resp_v[`TGT_MEM]      = mem_resp_v_i;
  assign tgt_resp_v[`TGT_IO]       = io_resp_v_i;
  assign tgt_resp_v[`TGT_CLINT]    = clint_resp_v;

  resp_router i_resp_router
  (
    .tgt_resp_i      (tgt_resp),
    .tgt_resp_v_i    (tgt_resp_v),
    .tgt_resp_yumi_o (tgt_resp_yumi),
    .req_resp_o      (req_resp_o),
    .req_resp_v_o    (req_resp_v_o),
    .req_resp_ready_i(req_resp_ready_i)
  );

  assign mem_resp_yumi_o = tgt_resp_yumi[`TGT_MEM];
  assign io_resp_yumi_o  = tgt_resp_yumi[`TGT_IO];

endmodule

`default_nettype wire
